//--- Makefile
# Verilator build and run for the banked register file

VERILATOR ?= verilator
TOP       ?= banked_regfile_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/banked_regfile_top.sv
// Banked register file top level
`timescale 1ns/1ps
`default_nettype none

module banked_regfile_top (
    input  logic                               clk,
    input  logic                               async_rst_n,
    input  logic                               req,
    input  regbank_pkg::cmd_op_e               op,
    input  logic [regbank_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [regbank_pkg::DATA_WIDTH-1:0] wdata,
    output logic                               ack,
    output logic [regbank_pkg::DATA_WIDTH-1:0] rdata
);
    import regbank_pkg::*;

    logic [NUM_BANKS-1:0]      bank_wr_en;
    logic [NUM_BANKS-1:0]      bank_clr;
    logic [REG_ADDR_WIDTH-1:0] reg_addr;
    logic [DATA_WIDTH-1:0]     wr_data;
    logic                      capture;
    logic [BANK_SEL_WIDTH-1:0] bank_sel;
    logic [DATA_WIDTH-1:0]     bank_rdata [NUM_BANKS];

    command_dispatch u_dispatch (
        .clk         (clk),
        .async_rst_n (async_rst_n),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .bank_wr_en  (bank_wr_en),
        .bank_clr    (bank_clr),
        .reg_addr    (reg_addr),
        .wr_data     (wr_data),
        .capture     (capture),
        .bank_sel    (bank_sel)
    );

    // One bank per strobe bit, address and data shared
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        dual_reset_regfile u_regfile (
            .clk         (clk),
            .async_rst_n (async_rst_n),
            .sync_rst    (bank_clr[b]),
            .write_en    (bank_wr_en[b]),
            .write_addr  (reg_addr),
            .write_data  (wr_data),
            .read_addr   (reg_addr),
            .read_data   (bank_rdata[b])
        );
    end

    read_collect u_collect (
        .clk         (clk),
        .async_rst_n (async_rst_n),
        .bank_rdata  (bank_rdata),
        .capture     (capture),
        .bank_sel    (bank_sel),
        .rdata       (rdata)
    );

endmodule

`default_nettype wire

//--- source/command_dispatch.sv
// Host command dispatcher
`timescale 1ns/1ps
`default_nettype none

module command_dispatch (
    input  logic                                   clk,
    input  logic                                   async_rst_n,
    input  logic                                   req,
    input  regbank_pkg::cmd_op_e                   op,
    input  logic [regbank_pkg::ADDR_WIDTH-1:0]     addr,
    input  logic [regbank_pkg::DATA_WIDTH-1:0]     wdata,
    output logic                                   ack,
    output logic [regbank_pkg::NUM_BANKS-1:0]      bank_wr_en,
    output logic [regbank_pkg::NUM_BANKS-1:0]      bank_clr,
    output logic [regbank_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
    output logic [regbank_pkg::DATA_WIDTH-1:0]     wr_data,
    output logic                                   capture,
    output logic [regbank_pkg::BANK_SEL_WIDTH-1:0] bank_sel
);
    import regbank_pkg::*;

    dispatch_state_e             state_q;
    dispatch_state_e             state_d;
    cmd_op_e                     op_q;
    logic [BANK_SEL_WIDTH-1:0]   bank_q;
    logic [REG_ADDR_WIDTH-1:0]   reg_addr_q;
    logic [DATA_WIDTH-1:0]       wr_data_q;
    logic [NUM_BANKS-1:0]        bank_onehot;

    logic accept;

    // Command is taken when req is seen in idle
    assign accept = (state_q == ST_IDLE) && req;

    // Fixed sequence, only ST_ACK waits on the host
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:   if (req) state_d = ST_ISSUE;
            ST_ISSUE:  state_d = ST_SETTLE;
            ST_SETTLE: state_d = ST_ACK;
            ST_ACK:    if (!req) state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            state_q    <= ST_IDLE;
            op_q       <= OP_NOP;
            bank_q     <= '0;
            reg_addr_q <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                op_q       <= op;
                bank_q     <= addr[ADDR_WIDTH-1 -: BANK_SEL_WIDTH];
                reg_addr_q <= addr[REG_ADDR_WIDTH-1:0];
            end
        end
    end

    // Write data held until the next command
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_data_q <= wdata;
        end
    end

    assign bank_onehot = {{(NUM_BANKS-1){1'b0}}, 1'b1} << bank_q;

    // Single-cycle strobes, nops and reads drive nothing here
    always_comb begin
        bank_wr_en = '0;
        bank_clr   = '0;
        if (state_q == ST_ISSUE) begin
            case (op_q)
                OP_WRITE: bank_wr_en = bank_onehot;
                OP_CLEAR: bank_clr   = bank_onehot;
                default:  bank_wr_en = '0;
            endcase
        end
    end

    // Bank read register is valid during settle
    assign capture  = (state_q == ST_SETTLE) && (op_q == OP_READ);
    assign ack      = (state_q == ST_ACK);
    assign reg_addr = reg_addr_q;
    assign wr_data  = wr_data_q;
    assign bank_sel = bank_q;

endmodule

`default_nettype wire

//--- source/dual_reset_regfile.sv
// Register bank with dual reset
`timescale 1ns/1ps
`default_nettype none

module dual_reset_regfile (
    input  logic                                  clk,
    input  logic                                  async_rst_n,
    input  logic                                  sync_rst,
    input  logic                                  write_en,
    input  logic [regbank_pkg::REG_ADDR_WIDTH-1:0] write_addr,
    input  logic [regbank_pkg::DATA_WIDTH-1:0]     write_data,
    input  logic [regbank_pkg::REG_ADDR_WIDTH-1:0] read_addr,
    output logic [regbank_pkg::DATA_WIDTH-1:0]     read_data
);
    import regbank_pkg::*;

    logic [DATA_WIDTH-1:0] regs [REGS_PER_BANK];

    // Array storage, clear wins over a write in the same cycle
    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            for (int i = 0; i < REGS_PER_BANK; i++) begin
                regs[i] <= '0;
            end
        end else if (sync_rst) begin
            for (int i = 0; i < REGS_PER_BANK; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    // Registered read port
    // Follows the addressed word one cycle behind the array
    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            read_data <= '0;
        end else if (sync_rst) begin
            read_data <= '0;
        end else begin
            read_data <= regs[read_addr];
        end
    end

endmodule

`default_nettype wire

//--- source/read_collect.sv
// Read response collector
`timescale 1ns/1ps
`default_nettype none

module read_collect (
    input  logic                                   clk,
    input  logic                                   async_rst_n,
    input  logic [regbank_pkg::DATA_WIDTH-1:0]     bank_rdata [regbank_pkg::NUM_BANKS],
    input  logic                                   capture,
    input  logic [regbank_pkg::BANK_SEL_WIDTH-1:0] bank_sel,
    output logic [regbank_pkg::DATA_WIDTH-1:0]     rdata
);
    import regbank_pkg::*;

    logic [DATA_WIDTH-1:0] sel_word;
    logic [DATA_WIDTH-1:0] rdata_q;

    // Bank mux
    assign sel_word = bank_rdata[bank_sel];

    // Response holds across writes, clears and nops
    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            rdata_q <= '0;
        end else if (capture) begin
            rdata_q <= sel_word;
        end
    end

    assign rdata = rdata_q;

endmodule

`default_nettype wire

//--- source/regbank_pkg.sv
// Banked register file shared definitions
`default_nettype none

package regbank_pkg;

    // Data path and bank geometry
    localparam int DATA_WIDTH     = 16;
    localparam int NUM_BANKS      = 4;
    localparam int BANK_SEL_WIDTH = 2;
    localparam int REG_ADDR_WIDTH = 4;
    localparam int REGS_PER_BANK  = 16;

    // Host address is bank index over register index
    localparam int ADDR_WIDTH     = BANK_SEL_WIDTH + REG_ADDR_WIDTH;

    // Host command opcodes
    typedef enum logic [1:0] {
        OP_NOP   = 2'b00,
        OP_WRITE = 2'b01,
        OP_READ  = 2'b10,
        OP_CLEAR = 2'b11
    } cmd_op_e;

    // Dispatcher FSM states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'b00,
        ST_ISSUE  = 2'b01,
        ST_SETTLE = 2'b10,
        ST_ACK    = 2'b11
    } dispatch_state_e;

endpackage

`default_nettype wire

//--- src.f
source/regbank_pkg.sv
source/dual_reset_regfile.sv
source/command_dispatch.sv
source/read_collect.sv
source/banked_regfile_top.sv
testbench/banked_regfile_assertions.sv
testbench/banked_regfile_tb.sv

//--- testbench/banked_regfile_assertions.sv
// Dispatcher handshake checks
`timescale 1ns/1ps
`default_nettype none

module banked_regfile_assertions (
    input logic                               clk,
    input logic                               async_rst_n,
    input logic                               req,
    input logic                               ack,
    input logic [regbank_pkg::NUM_BANKS-1:0]  bank_wr_en,
    input logic [regbank_pkg::NUM_BANKS-1:0]  bank_clr,
    input logic                               capture,
    input regbank_pkg::dispatch_state_e       state_q
);
    import regbank_pkg::*;

    logic any_strobe;
    // Count of failed assertions
    int   fail_count = 0;

    assign any_strobe = (|bank_wr_en) || (|bank_clr);

    // At most one strobe bit over both buses
    strobe_onehot: assert property (@(posedge clk) disable iff (!async_rst_n)
        $onehot0({bank_wr_en, bank_clr}))
        else begin
            $error("more than one bank strobe active");
            fail_count++;
        end

    strobe_single_cycle: assert property (@(posedge clk) disable iff (!async_rst_n)
        any_strobe |=> !any_strobe)
        else begin
            $error("bank strobe held longer than one cycle");
            fail_count++;
        end

    // ack stays up while the host still holds req
    ack_held_by_req: assert property (@(posedge clk) disable iff (!async_rst_n)
        (ack && req) |=> ack)
        else begin
            $error("ack dropped while req was high");
            fail_count++;
        end

    capture_in_settle: assert property (@(posedge clk) disable iff (!async_rst_n)
        capture |-> (state_q == ST_SETTLE))
        else begin
            $error("capture outside the settle state");
            fail_count++;
        end

endmodule

bind command_dispatch banked_regfile_assertions u_assertions (
    .clk         (clk),
    .async_rst_n (async_rst_n),
    .req         (req),
    .ack         (ack),
    .bank_wr_en  (bank_wr_en),
    .bank_clr    (bank_clr),
    .capture     (capture),
    .state_q     (state_q)
);

`default_nettype wire

//--- testbench/banked_regfile_tb.sv
// Banked register file testbench
`timescale 1ns/1ps
`default_nettype none

module banked_regfile_tb;
    import regbank_pkg::*;

    localparam int TIMEOUT_CYCLES   = 20;
    localparam int EXPECTED_LATENCY = 3;

    typedef struct {
        cmd_op_e               op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        bit                    rand_data;
    } cmd_entry_t;

    logic                  clk;
    logic                  async_rst_n;
    logic                  req;
    cmd_op_e               op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  ack;
    logic [DATA_WIDTH-1:0] rdata;

    cmd_entry_t            cmd_table [$];
    // Reference contents by full host address
    logic [DATA_WIDTH-1:0] model [NUM_BANKS*REGS_PER_BANK];
    logic [DATA_WIDTH-1:0] last_read;

    banked_regfile_top uut (
        .clk         (clk),
        .async_rst_n (async_rst_n),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .rdata       (rdata)
    );

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] actual,
                              input logic [DATA_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h",
                     $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_level(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b",
                     $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_latency(input int actual);
        if (actual != EXPECTED_LATENCY) begin
            $display("CHECK FAILED at %0t: ack latency got %0d expected %0d",
                     $time, actual, EXPECTED_LATENCY);
            stop_run();
        end
    endtask

    task automatic check_assertions();
        if (uut.u_dispatch.u_assertions.fail_count != 0) begin
            $display("Dispatcher assertion failed before %0t", $time);
            stop_run();
        end
    endtask

    task automatic add_entry(input cmd_op_e cmd, input int bank, input int reg_idx,
                             input logic [DATA_WIDTH-1:0] data, input bit rand_data);
        cmd_entry_t e;
        e.op        = cmd;
        e.addr      = {bank[BANK_SEL_WIDTH-1:0], reg_idx[REG_ADDR_WIDTH-1:0]};
        e.data      = data;
        e.rand_data = rand_data;
        cmd_table.push_back(e);
    endtask

    task automatic fill_command_table();
        // Everything reads zero out of reset
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int r = 0; r < REGS_PER_BANK; r++) begin
                add_entry(OP_READ, b, r, '0, 1'b0);
            end
        end
        // Same register index in every bank
        for (int b = 0; b < NUM_BANKS; b++) begin
            add_entry(OP_WRITE, b, 5, '0, 1'b1);
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            add_entry(OP_READ, b, 5, '0, 1'b0);
        end
        add_entry(OP_WRITE, 1, 0, 16'h1234, 1'b0);
        add_entry(OP_WRITE, 2, 15, '0, 1'b1);
        add_entry(OP_WRITE, 3, 7, 16'hbeef, 1'b0);
        add_entry(OP_READ, 1, 0, '0, 1'b0);
        // Response must hold over non-read commands
        add_entry(OP_NOP, 0, 0, '0, 1'b0);
        add_entry(OP_WRITE, 1, 0, 16'h5a5a, 1'b0);
        add_entry(OP_CLEAR, 1, 0, '0, 1'b0);
        add_entry(OP_NOP, 3, 9, '0, 1'b0);
        add_entry(OP_READ, 3, 7, '0, 1'b0);
        // Fill bank 2, clear it, then sweep all banks
        for (int r = 0; r < REGS_PER_BANK; r++) begin
            add_entry(OP_WRITE, 2, r, '0, 1'b1);
        end
        add_entry(OP_CLEAR, 2, 0, '0, 1'b0);
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int r = 0; r < REGS_PER_BANK; r++) begin
                add_entry(OP_READ, b, r, '0, 1'b0);
            end
        end
    endtask

    task automatic run_command(input cmd_entry_t e);
        logic [31:0]               rnd;
        logic [DATA_WIDTH-1:0]     data;
        logic [BANK_SEL_WIDTH-1:0] bank;
        int                        cycles;
        int                        extra;
        int                        gap;

        data = e.data;
        if (e.rand_data) begin
            rnd  = $urandom;
            data = rnd[DATA_WIDTH-1:0];
        end
        bank = e.addr[ADDR_WIDTH-1 -: BANK_SEL_WIDTH];

        // Reference model update
        case (e.op)
            OP_WRITE: model[e.addr] = data;
            OP_CLEAR: begin
                for (int i = 0; i < REGS_PER_BANK; i++) begin
                    model[{bank, i[REG_ADDR_WIDTH-1:0]}] = '0;
                end
            end
            OP_READ:  last_read = model[e.addr];
            default:  ;
        endcase

        @(posedge clk);
        req   <= 1'b1;
        op    <= e.op;
        addr  <= e.addr;
        wdata <= data;

        cycles = 0;
        while (ack !== 1'b1) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timeout: ack did not rise within %0d cycles of req", TIMEOUT_CYCLES);
                stop_run();
            end
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        check_latency(cycles);
        check_data("rdata", rdata, last_read);

        // Host stalls with req high
        extra = $urandom_range(3, 0);
        repeat (extra) begin
            @(posedge clk);
            @(negedge clk);
            check_level("ack", ack, 1'b1);
        end

        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (ack !== 1'b0) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timeout: ack did not fall within %0d cycles of req low",
                         TIMEOUT_CYCLES);
                stop_run();
            end
            @(negedge clk);
            cycles++;
        end
        check_data("rdata", rdata, last_read);

        gap = $urandom_range(3, 0);
        repeat (gap) @(posedge clk);
    endtask

    initial begin
        clk         = 1'b0;
        async_rst_n = 1'b0;
        req         = 1'b0;
        op          = OP_NOP;
        addr        = '0;
        wdata       = '0;
        last_read   = '0;
        model       = '{default: '0};
        void'($urandom(32'hcb80_fabe));
        fill_command_table();

        repeat (10) @(posedge clk);
        async_rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        foreach (cmd_table[i]) begin
            run_command(cmd_table[i]);
            check_assertions();
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
